// ==== hdl/microcodePkg.sv ====
// -------------------------------------------------------------------------
// Microcode definitions for the calculator control store
// Field widths, branch operations, register destinations, fixed addresses
// -------------------------------------------------------------------------
`default_nettype none

package microcodePkg;

        // -----------------------------------------------------------------
        // Microword field widths
        localparam int uAddrW = 8;                              // Microaddress
        localparam int bopW   = 4;                              // Branch op
        localparam int destW  = 3;                              // Destination

        // -----------------------------------------------------------------
        // Branch operations
        localparam logic [bopW-1:0] bopCount     = 4'b0110;    // Next word
        localparam logic [bopW-1:0] bopBranch    = 4'b1110;    // Always jump
        localparam logic [bopW-1:0] bopGoN       = 4'b0100;    // Loop while goN high
        localparam logic [bopW-1:0] bopGoHeld    = 4'b1100;    // Loop while goN low
        localparam logic [bopW-1:0] bopZero      = 4'b1101;    // Jump on zero
        localparam logic [bopW-1:0] bopNotZero   = 4'b0101;    // Jump on nonzero
        localparam logic [bopW-1:0] bopOpcode    = 4'b1111;    // Opcode dispatch

        // -----------------------------------------------------------------
        // Register destinations
        localparam logic [destW-1:0] destTbTa    = 3'b100;     // Both temps
        localparam logic [destW-1:0] destTb      = 3'b101;     // Temp B
        localparam logic [destW-1:0] destTa      = 3'b110;     // Temp A
        localparam logic [destW-1:0] destFTa     = 3'b010;     // F and temp A
        localparam logic [destW-1:0] destF       = 3'b011;     // F only
        localparam logic [destW-1:0] destNone    = 3'b111;     // No write

        // Fixed entry points
        localparam logic [uAddrW-1:0] uAddrReset  = 8'h00;     // Reset flash start
        localparam logic [uAddrW-1:0] uAddrWaitGo = 8'h0D;     // Idle wait on goN

endpackage

`default_nettype wire

// ==== hdl/aluPkg.sv ====
// -------------------------------------------------------------------------
// Datapath definitions: data width, ALU function codes, opcodes
// -------------------------------------------------------------------------
`default_nettype none

package aluPkg;

        localparam int dataW = 8;                               // Datapath
        localparam int opW   = 4;                               // Opcode
        localparam int funcW = 5;                               // ALU function

        // ALU functions
        localparam logic [funcW-1:0] aluA       = 5'b00000;    // Pass A
        localparam logic [funcW-1:0] aluAPlusB  = 5'b01001;    // A+B+cin
        localparam logic [funcW-1:0] aluAMinusB = 5'b00110;    // A-B-1+cin
        localparam logic [funcW-1:0] aluAMinus1 = 5'b01111;    // Decrement
        localparam logic [funcW-1:0] aluB       = 5'b11010;    // Pass B
        localparam logic [funcW-1:0] aluZero    = 5'b10011;    // All zeros
        localparam logic [funcW-1:0] aluOnes    = 5'b11100;    // All ones

        // Supported opcodes
        localparam logic [opW-1:0] opAdd = 4'b0011;
        localparam logic [opW-1:0] opSub = 4'b0111;
        localparam logic [opW-1:0] opMul = 4'b1100;             // Repeated add

endpackage

`default_nettype wire

// ==== hdl/aluUnit.sv ====
// -------------------------------------------------------------------------
// 8-bit ALU with carry-in and zero flag
// -------------------------------------------------------------------------
`default_nettype none

module aluUnit (
        input  logic [aluPkg::dataW-1:0] aOp,
        input  logic [aluPkg::dataW-1:0] bOp,
        input  logic [aluPkg::funcW-1:0] aluFunc,
        input  logic                     cin,
        output logic [aluPkg::dataW-1:0] aluOut,
        output logic                     aluZero
);

        logic [aluPkg::dataW-1:0] cinExt;               // Carry as an operand

        assign cinExt = {{(aluPkg::dataW-1){1'b0}}, cin};

        always_comb begin
                case (aluFunc)
                aluPkg::aluA:       aluOut = aOp;
                aluPkg::aluAPlusB:  aluOut = aOp + bOp + cinExt;
                aluPkg::aluAMinusB: aluOut = aOp + ~bOp + cinExt;       // Ones complement B
                aluPkg::aluAMinus1: aluOut = aOp + '1;                  // Adding ones wraps
                aluPkg::aluB:       aluOut = bOp;
                aluPkg::aluZero:    aluOut = '0;
                default:            aluOut = '1;                        // Ones, unknown too
                endcase
        end

        assign aluZero = (aluOut == '0);                // Feeds branch test

endmodule

`default_nettype wire

// ==== hdl/controlStore.sv ====
// -------------------------------------------------------------------------
// Microcode ROM: reset flash, idle wait, dispatch, ADD, SUBTRACT, MULTIPLY
// -------------------------------------------------------------------------
`default_nettype none

module controlStore (
        input  logic [microcodePkg::uAddrW-1:0] uAddr,
        output logic [aluPkg::funcW-1:0]        aluFunc,
        output logic                            cin,
        output logic                            aSel,           // 1 input A, 0 temp A
        output logic                            bSel,           // 1 input B, 0 temp B
        output logic [microcodePkg::destW-1:0]  dest,
        output logic [microcodePkg::bopW-1:0]   bop,
        output logic [microcodePkg::uAddrW-1:0] target
);

        always_comb begin
                // Idle word, each address overrides what it needs
                aluFunc = aluPkg::aluOnes;                      // Ones
                cin     = 1'b0;                                 // No carry
                aSel    = 1'b1;                                 // Input A
                bSel    = 1'b1;                                 // Input B
                dest    = microcodePkg::destNone;               // No write
                bop     = microcodePkg::bopCount;               // Next word
                target  = microcodePkg::uAddrReset;             // Don't care
                case (uAddr)
                // ---------------------------------------------------------
                // Reset flash and wait
                microcodePkg::uAddrReset: begin                 // Flash ones
                        dest   = microcodePkg::destF;           // F
                        bop    = microcodePkg::bopBranch;       // Always
                        target = 8'h0B;                         // Temp preset
                end
                8'h0B: dest = microcodePkg::destTbTa;           // Temps to ones
                8'h0C: begin                                    // Flash zero
                        aluFunc = aluPkg::aluZero;              // Zero
                        dest    = microcodePkg::destF;          // F
                end
                microcodePkg::uAddrWaitGo: begin                // Ones until goN low
                        dest   = microcodePkg::destF;           // F
                        bop    = microcodePkg::bopGoN;          // Loop here
                        target = microcodePkg::uAddrWaitGo;
                end
                8'h0E: begin                                    // Latch inputs, dispatch
                        bop    = microcodePkg::bopOpcode;       // Opcode in high nibble
                        target = 8'h01;                         // Low nibble 1
                end
                // ---------------------------------------------------------
                // ADD and SUBTRACT
                {aluPkg::opAdd, 4'h1}: begin
                        aluFunc = aluPkg::aluAPlusB;            // A+B
                        dest    = microcodePkg::destF;          // F
                end
                {aluPkg::opSub, 4'h1}: begin
                        aluFunc = aluPkg::aluAMinusB;           // A-B-1+cin
                        cin     = 1'b1;                         // Makes it A-B
                        dest    = microcodePkg::destF;          // F
                end
                {aluPkg::opAdd, 4'h2}, {aluPkg::opSub, 4'h2}: begin
                        bop    = microcodePkg::bopGoHeld;       // Hold result
                        target = uAddr;                         // Loop here
                end
                {aluPkg::opAdd, 4'h3}, {aluPkg::opSub, 4'h3}: begin
                        aluFunc = aluPkg::aluZero;              // Flash zero
                        dest    = microcodePkg::destF;          // F
                        bop     = microcodePkg::bopBranch;      // Back to idle
                        target  = microcodePkg::uAddrWaitGo;
                end
                // ---------------------------------------------------------
                // MULTIPLY, temp A counts B down, temp B sums A
                {aluPkg::opMul, 4'h1}: begin
                        aluFunc = aluPkg::aluZero;              // Clear
                        dest    = microcodePkg::destTb;         // Sum
                end
                {aluPkg::opMul, 4'h2}: begin
                        aluFunc = aluPkg::aluB;                 // Input B
                        dest    = microcodePkg::destF;          // F
                        bop     = microcodePkg::bopZero;        // B zero, done
                        target  = {aluPkg::opMul, 4'h7};
                end
                {aluPkg::opMul, 4'h3}: begin
                        aluFunc = aluPkg::aluB;                 // Input B
                        dest    = microcodePkg::destTa;         // Counter
                        bop     = microcodePkg::bopBranch;      // Into the add loop
                        target  = {aluPkg::opMul, 4'h5};
                end
                {aluPkg::opMul, 4'h5}: begin
                        aluFunc = aluPkg::aluAPlusB;            // Input A + sum
                        bSel    = 1'b0;                         // Temp B
                        dest    = microcodePkg::destTb;
                end
                {aluPkg::opMul, 4'h6}: begin
                        aluFunc = aluPkg::aluAMinus1;           // Count down
                        aSel    = 1'b0;                         // Temp A
                        dest    = microcodePkg::destFTa;
                        bop     = microcodePkg::bopNotZero;     // More adds left
                        target  = {aluPkg::opMul, 4'h5};
                end
                {aluPkg::opMul, 4'h7}: begin
                        aluFunc = aluPkg::aluB;                 // Product
                        bSel    = 1'b0;                         // Temp B
                        dest    = microcodePkg::destF;
                        bop     = microcodePkg::bopGoHeld;      // Hold result
                        target  = {aluPkg::opMul, 4'h7};
                end
                {aluPkg::opMul, 4'h8}: begin
                        aluFunc = aluPkg::aluZero;              // Flash zero
                        dest    = microcodePkg::destF;
                        bop     = microcodePkg::bopBranch;      // Back to idle
                        target  = microcodePkg::uAddrWaitGo;
                end
                default: begin                                  // Unused, restart
                        dest = microcodePkg::destF;             // Ones on F
                        bop  = microcodePkg::bopBranch;         // To reset word
                end
                endcase
        end

endmodule

`default_nettype wire

// ==== hdl/microSequencer.sv ====
// -------------------------------------------------------------------------
// Micro program counter with branch condition select and opcode dispatch
// -------------------------------------------------------------------------
`default_nettype none

module microSequencer (
        input  logic                            clk,
        input  logic                            rstN,
        input  logic                            goN,
        input  logic                            aluZero,
        input  logic [microcodePkg::bopW-1:0]   bop,
        input  logic [microcodePkg::uAddrW-1:0] target,
        input  logic [aluPkg::opW-1:0]          opcode,
        output logic                            load,   // Input latch strobe
        output logic [microcodePkg::uAddrW-1:0] uAddr
);

        logic [microcodePkg::uAddrW-1:0] uAddrInc;      // Fall-through address
        logic [microcodePkg::uAddrW-1:0] uAddrNext;

        assign uAddrInc = uAddr + {{(microcodePkg::uAddrW-1){1'b0}}, 1'b1};
        assign load     = (bop == microcodePkg::bopOpcode);

        always_comb begin
                case (bop)
                microcodePkg::bopCount:   uAddrNext = uAddrInc;
                microcodePkg::bopBranch:  uAddrNext = target;
                microcodePkg::bopGoN:     uAddrNext = goN ? target : uAddrInc;
                microcodePkg::bopGoHeld:  uAddrNext = goN ? uAddrInc : target;
                microcodePkg::bopZero:    uAddrNext = aluZero ? target : uAddrInc;
                microcodePkg::bopNotZero: uAddrNext = aluZero ? uAddrInc : target;
                microcodePkg::bopOpcode:                        // Routine entry
                        uAddrNext = {opcode,
                                     target[microcodePkg::uAddrW-aluPkg::opW-1:0]};
                default:                  uAddrNext = microcodePkg::uAddrReset;
                endcase
        end

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        uAddr <= microcodePkg::uAddrReset;
                end else begin
                        uAddr <= uAddrNext;                     // One word per clock
                end
        end

endmodule

`default_nettype wire

// ==== hdl/regBank.sv ====
// -------------------------------------------------------------------------
// Input, temp and F registers with operand muxes and write decode
// -------------------------------------------------------------------------
`default_nettype none

module regBank (
        input  logic                           clk,
        input  logic                           rstN,
        input  logic                           load,
        input  logic [aluPkg::opW-1:0]         opcode,
        input  logic [aluPkg::dataW-1:0]       dataA,
        input  logic [aluPkg::dataW-1:0]       dataB,
        input  logic                           aSel,
        input  logic                           bSel,
        input  logic [microcodePkg::destW-1:0] dest,
        input  logic [aluPkg::dataW-1:0]       aluOut,
        output logic [aluPkg::dataW-1:0]       aOp,
        output logic [aluPkg::dataW-1:0]       bOp,
        output logic [aluPkg::opW-1:0]         opcodeReg,
        output logic [aluPkg::dataW-1:0]       result   // F register
);

        logic [aluPkg::opW-1:0]   opcodeQ;
        logic [aluPkg::dataW-1:0] inA;
        logic [aluPkg::dataW-1:0] inB;
        logic [aluPkg::dataW-1:0] tempA;
        logic [aluPkg::dataW-1:0] tempB;
        logic                     wrTa;
        logic                     wrTb;
        logic                     wrF;

        assign wrTa = dest inside {microcodePkg::destTbTa, microcodePkg::destTa,
                                   microcodePkg::destFTa};
        assign wrTb = dest inside {microcodePkg::destTbTa, microcodePkg::destTb};
        assign wrF  = dest inside {microcodePkg::destFTa, microcodePkg::destF};

        assign aOp       = aSel ? inA : tempA;
        assign bOp       = bSel ? inB : tempB;
        assign opcodeReg = load ? opcode : opcodeQ;     // Dispatch sees new opcode

        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        opcodeQ <= '0;
                        inA     <= '0;
                        inB     <= '0;
                        tempA   <= '0;
                        tempB   <= '0;
                        result  <= '0;
                end else begin
                        if (load) begin                 // Dispatch word
                                opcodeQ <= opcode;
                                inA     <= dataA;
                                inB     <= dataB;
                        end
                        if (wrTa) tempA  <= aluOut;
                        if (wrTb) tempB  <= aluOut;
                        if (wrF)  result <= aluOut;
                end
        end

endmodule

`default_nettype wire

// ==== hdl/microCalc.sv ====
// -------------------------------------------------------------------------
// Microprogrammed 8-bit calculator top level
// -------------------------------------------------------------------------
`default_nettype none

module microCalc (
        input  logic                     clk,
        input  logic                     rstN,
        input  logic                     goN,           // Start, active low
        input  logic [aluPkg::opW-1:0]   opcode,
        input  logic [aluPkg::dataW-1:0] dataA,
        input  logic [aluPkg::dataW-1:0] dataB,
        output logic [aluPkg::dataW-1:0] result
);

        logic [microcodePkg::uAddrW-1:0] uAddr;
        logic [microcodePkg::uAddrW-1:0] target;
        logic [microcodePkg::bopW-1:0]   bop;
        logic [microcodePkg::destW-1:0]  dest;
        logic [aluPkg::funcW-1:0]        aluFunc;
        logic [aluPkg::dataW-1:0]        aOp;
        logic [aluPkg::dataW-1:0]        bOp;
        logic [aluPkg::dataW-1:0]        aluOut;
        logic [aluPkg::opW-1:0]          opcodeReg;
        logic                            cin;
        logic                            aSel;
        logic                            bSel;
        logic                            aluZero;
        logic                            load;

        microSequencer i_seq (.clk(clk), .rstN(rstN), .goN(goN), .aluZero(aluZero),
                              .bop(bop), .target(target), .opcode(opcodeReg),
                              .load(load), .uAddr(uAddr));

        controlStore i_store (.uAddr(uAddr), .aluFunc(aluFunc), .cin(cin), .aSel(aSel),
                              .bSel(bSel), .dest(dest), .bop(bop), .target(target));

        aluUnit i_alu (.aOp(aOp), .bOp(bOp), .aluFunc(aluFunc), .cin(cin),
                       .aluOut(aluOut), .aluZero(aluZero));

        regBank i_regs (.clk(clk), .rstN(rstN), .load(load), .opcode(opcode),
                        .dataA(dataA), .dataB(dataB), .aSel(aSel), .bSel(bSel),
                        .dest(dest), .aluOut(aluOut), .aOp(aOp), .bOp(bOp),
                        .opcodeReg(opcodeReg), .result(result));

endmodule

`default_nettype wire

// ==== dv/microCalcTb.sv ====
// -------------------------------------------------------------------------
// Testbench for the microprogrammed calculator
// Table rows and LCG rows run through goN handshakes, results checked on F
// -------------------------------------------------------------------------
`default_nettype none

module microCalcTb;

        logic                     clk;
        logic                     rstN;
        logic                     goN;
        logic [aluPkg::opW-1:0]   opcode;
        logic [aluPkg::dataW-1:0] dataA;
        logic [aluPkg::dataW-1:0] dataB;
        logic [aluPkg::dataW-1:0] result;

        int errCount     = 0;                           // Wrong values
        int timeoutCount = 0;                           // Waits that ran out

        // Rows are {opcode, dataA, dataB, expected F}
        logic [27:0] stimTable [0:14] = '{
                28'h3_12_34_46, 28'h3_FF_01_00, 28'h3_80_80_00, 28'h3_7F_01_80,
                28'h7_50_20_30, 28'h7_00_01_FF, 28'h7_05_05_00, 28'h7_10_F0_20,
                28'hC_07_06_2A, 28'hC_35_00_00, 28'hC_9C_01_9C, 28'hC_FF_FF_01,
                28'hC_10_10_00,
                28'h5_12_34_FF,                         // Unused opcode
                28'h3_21_43_64                          // ADD after the unused one
        };

        microCalc i_dut (.clk(clk), .rstN(rstN), .goN(goN), .opcode(opcode),
                         .dataA(dataA), .dataB(dataB), .result(result));

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;                 // Period 20
        end

        // -----------------------------------------------------------------
        // Helpers
        function automatic logic [31:0] lcgNext(input logic [31:0] s);
                lcgNext = s * 32'd1664525 + 32'd1013904223;
        endfunction

        function automatic logic [7:0] modelResult(input logic [3:0] op,
                                                   input logic [7:0] a,
                                                   input logic [7:0] b);
                logic [15:0] prod;
                prod = {8'h00, a} * {8'h00, b};
                case (op)
                aluPkg::opAdd: modelResult = a + b;     // Wraps at 256
                aluPkg::opSub: modelResult = a - b;
                aluPkg::opMul: modelResult = prod[7:0]; // Low byte
                default:       modelResult = 8'hFF;     // Machine stays idle
                endcase
        endfunction

        task automatic stepClk();
                @(posedge clk);
                #2;                                     // Sample, then drive
        endtask

        task automatic checkValue(input logic [7:0] actual, input logic [7:0] expected,
                                  input string what);
                if (actual !== expected) begin
                        errCount++;
                        $display("Error at %0t: %s, got %02h expected %02h",
                                 $time, what, actual, expected);
                end
        endtask

        // Wait until F shows want on runLen samples in a row
        task automatic waitValue(input logic [7:0] want, input int limit, input int runLen,
                                 input string what, output bit ok);
                int n;
                int seen;
                ok   = 1'b0;
                seen = 0;
                for (n = 0; n < limit + runLen - 1 && !ok; n++) begin
                        stepClk();
                        seen = (result === want) ? seen + 1 : 0;
                        ok   = (seen >= runLen);
                end
                if (!ok) begin
                        timeoutCount++;
                        $display("Timed out after %0d cycles waiting for %s", n, what);
                end
        endtask

        task automatic releaseGo();
                bit ok;
                goN = 1'b1;
                waitValue(8'h00, 3, 1, "zero flash after release", ok);
                waitValue(8'hFF, 2, 1, "ones after the zero flash", ok);
        endtask

        // -----------------------------------------------------------------
        // One operation through the goN handshake
        task automatic runRow(input logic [3:0] op, input logic [7:0] a,
                              input logic [7:0] b, input logic [7:0] exp);
                bit ok;
                int k;
                checkValue(result, 8'hFF, "idle value before start");
                opcode = op;
                dataA  = a;
                dataB  = b;
                goN    = 1'b0;                          // Start
                stepClk();
                stepClk();                              // Inputs latched now
                dataA  = ~a;                            // Must not reach F
                dataB  = ~b;
                if (op == aluPkg::opAdd || op == aluPkg::opSub) begin
                        checkValue(result, 8'hFF, "ones during dispatch");
                        stepClk();
                        checkValue(result, exp, "result three edges after start");
                        ok = 1'b1;
                end else if (op == aluPkg::opMul) begin
                        waitValue(exp, 598, 4, "multiply result", ok);  // By edge 600
                end else begin
                        ok = 1'b0;
                end
                if (op == aluPkg::opAdd || op == aluPkg::opSub || op == aluPkg::opMul) begin
                        for (k = 0; k < 10 && ok; k++) begin
                                stepClk();
                                checkValue(result, exp, "result held while goN low");
                        end
                        releaseGo();
                end else begin                          // Unused, restart loop
                        repeat (4) stepClk();
                        goN = 1'b1;
                        waitValue(8'hFF, 8, 1, "ones after unused opcode", ok);
                        repeat (8) stepClk();           // Settle in wait loop
                end
        endtask

        // -----------------------------------------------------------------
        // Main sequence
        initial begin
                int          i;
                bit          ok;
                logic [31:0] seed;
                logic [3:0]  op;
                logic [7:0]  a;
                logic [7:0]  b;
                rstN   = 1'b0;
                goN    = 1'b1;
                opcode = '0;
                dataA  = '0;
                dataB  = '0;
                seed   = 32'h43f0;
                repeat (5) @(posedge clk);              // Reset for 5 cycles
                #2;
                rstN = 1'b1;
                waitValue(8'hFF, 4, 1, "ones after reset", ok);
                repeat (6) stepClk();                   // Through the flash
                for (i = 0; i < 15; i++) begin
                        runRow(stimTable[i][27:24], stimTable[i][23:16],
                               stimTable[i][15:8], stimTable[i][7:0]);
                end
                for (i = 0; i < 20; i++) begin          // Random operands
                        seed = lcgNext(seed);
                        case (seed[17:16])
                        2'd0:    op = aluPkg::opAdd;
                        2'd1:    op = aluPkg::opSub;
                        default: op = aluPkg::opMul;
                        endcase
                        seed = lcgNext(seed);
                        a    = seed[23:16];
                        seed = lcgNext(seed);
                        b    = seed[23:16];
                        runRow(op, a, b, modelResult(op, a, b));
                end
                $display("Finished with %0d check errors and %0d timeouts",
                         errCount, timeoutCount);
                if (errCount == 0 && timeoutCount == 0) begin
                        $display("All tests passed");
                end else begin
                        $display("Some tests failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== microCalc.f ====
hdl/microcodePkg.sv
hdl/aluPkg.sv
hdl/aluUnit.sv
hdl/controlStore.sv
hdl/microSequencer.sv
hdl/regBank.sv
hdl/microCalc.sv
dv/microCalcTb.sv

// ==== Makefile ====
# Verilator build and run for the microprogrammed calculator

SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = microCalcTb
FILELIST = microCalc.f
BUILDDIR = obj_dir
LOG      = sim.log
PASSMSG  = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR) -o $(TOP)
	./$(BUILDDIR)/$(TOP) | tee $(LOG)
	@grep -qx "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
